//--- common/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Register id widths
`define ARF_WIDTH     5
`define PRF_WIDTH     6

// Register file sizes
`define NUM_ARF       32
`define NUM_PRF       64   // Architectural plus rename registers

// Free list ring
`define FL_DEPTH      32   // NUM_PRF - NUM_ARF ids in flight at most
`define FL_PTR_WIDTH  5

`endif

//--- common/rename_pkg.sv
`default_nettype none
`include "rename_consts.svh"

package rename_pkg;

   // State reported by the reorder buffer
   typedef enum logic [1:0] {
      ROB_NORMAL  = 2'b00,
      ROB_RECOVER = 2'b01,  // Misprediction walk in progress
      ROB_IDLE    = 2'b10
   } rob_state_e;

   // Rename side recovery states
   typedef enum logic [1:0] {
      ST_RUN    = 2'b00,
      ST_WALK   = 2'b01,
      ST_RESUME = 2'b10     // One stall cycle after the walk
   } recov_state_e;

   // Decoded instruction, 17 bits
   typedef struct packed {
      logic                  is_valid;
      logic                  reg_write;
      logic [`ARF_WIDTH-1:0] rd_id;
      logic [`ARF_WIDTH-1:0] rs1_id;
      logic [`ARF_WIDTH-1:0] rs2_id;
   } dec_instr_t;

   // Renamed instruction, 24 bits
   typedef struct packed {
      logic [`PRF_WIDTH-1:0] prf_rs1;
      logic [`PRF_WIDTH-1:0] prf_rs2;
      logic [`PRF_WIDTH-1:0] t_new;  // Freshly allocated
      logic [`PRF_WIDTH-1:0] t_old;  // Previous mapping, freed at retire
   } rename_out_t;

   // Register handed back at retire
   typedef struct packed {
      logic                  valid;
      logic [`PRF_WIDTH-1:0] prf_id;
   } release_t;

   // Alias table restore entry
   typedef struct packed {
      logic                  valid;
      logic [`ARF_WIDTH-1:0] rd_id;
      logic [`PRF_WIDTH-1:0] rd_prf;
   } walk_t;

endpackage
`default_nettype wire

//--- logic/recovery_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module recovery_fsm (
   input  logic                   clk,
   input  logic                   rst_n,
   input  rename_pkg::rob_state_e rob_state,
   output logic                   rename_en,  // Allocate and write table
   output logic                   walk_en     // Accept walk strobes
);
   import rename_pkg::*;

   recov_state_e state, state_nxt;
   logic         in_recover;

   assign in_recover = (rob_state == ROB_RECOVER);

   always_comb begin
      state_nxt = state;
      case (state)
         ST_RUN: begin
            if (in_recover) begin
               state_nxt = ST_WALK;
            end
         end
         ST_WALK: begin
            if (!in_recover) begin
               state_nxt = ST_RESUME;  // ROB finished walking
            end
         end
         ST_RESUME: begin
            // Last table restore lands on this edge
            state_nxt = in_recover ? ST_WALK : ST_RUN;
         end
         default: state_nxt = ST_RUN;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_RUN;
      end else begin
         state <= state_nxt;
      end
   end

   // Stall renaming in walk and resume
   assign rename_en = (state == ST_RUN);
   assign walk_en   = (state == ST_WALK);

endmodule
`default_nettype wire

//--- logic/free_count.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_consts.svh"

module free_count (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [1:0] pop_cnt,   // Ids handed out
   input  logic [1:0] push_cnt,  // Ids released at retire
   input  logic [1:0] walk_cnt,  // Ids walked back on recovery
   output logic       can_alloc
);

   localparam int CNT_W = `FL_PTR_WIDTH + 1;  // Holds 0 to FL_DEPTH

   logic [CNT_W-1:0] free_cnt;
   logic [CNT_W-1:0] free_cnt_nxt;

   // Never goes below zero, pops need can_alloc
   assign free_cnt_nxt = free_cnt
                       + CNT_W'(push_cnt)
                       + CNT_W'(walk_cnt)
                       - CNT_W'(pop_cnt);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         free_cnt <= CNT_W'(`FL_DEPTH);  // Ring starts full
      end else begin
         free_cnt <= free_cnt_nxt;
      end
   end

   // Two free covers a full pair
   assign can_alloc = (free_cnt >= CNT_W'(2));

endmodule
`default_nettype wire

//--- rename/free_list.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_consts.svh"

module free_list (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  pop_0,       // Take head
   input  logic                  pop_1,       // Take head + 1, only with pop_0
   input  rename_pkg::release_t  release_0,
   input  rename_pkg::release_t  release_1,
   input  logic                  walk_en,
   input  logic                  fl_walk_0,
   input  logic                  fl_walk_1,
   output logic [`PRF_WIDTH-1:0] head_prf_0,
   output logic [`PRF_WIDTH-1:0] head_prf_1
);

   localparam int PW = `FL_PTR_WIDTH;

   logic [`PRF_WIDTH-1:0] ring [`FL_DEPTH];
   logic [PW-1:0]         head;
   logic [PW-1:0]         tail;       // Next slot to fill
   logic [PW-1:0]         head_nxt;
   logic [PW-1:0]         pop_amt;
   logic [PW-1:0]         walk_amt;
   logic [PW-1:0]         tail_1;     // Slot for release_1

   // Pointers wrap naturally at FL_DEPTH
   assign pop_amt  = PW'(pop_0) + PW'(pop_1);
   assign walk_amt = walk_en ? (PW'(fl_walk_0) + PW'(fl_walk_1)) : '0;
   assign head_nxt = head + pop_amt - walk_amt;

   // Release 1 packs behind release 0
   assign tail_1 = tail + PW'(release_0.valid);

   assign head_prf_0 = ring[head];
   assign head_prf_1 = ring[head + PW'(1)];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         head <= '0;
         tail <= '0;   // Ring full, tail meets head
      end else begin
         head <= head_nxt;
         tail <= tail_1 + PW'(release_1.valid);
      end
   end

   // Ring content, starting with the ids above the architectural range
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `FL_DEPTH; i++) begin
            ring[i] <= `PRF_WIDTH'(`NUM_ARF + i);
         end
      end else begin
         if (release_0.valid) begin
            ring[tail] <= release_0.prf_id;
         end
         if (release_1.valid) begin
            ring[tail_1] <= release_1.prf_id;
         end
      end
   end

   // Walked-back slots keep their ids
   // The tail stays behind them while the count stays at or under FL_DEPTH
   // So the next pops hand the same ids out again

endmodule
`default_nettype wire

//--- rename/map_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_consts.svh"

module map_table (
   input  logic                    clk,
   input  logic                    rst_n,
   input  rename_pkg::dec_instr_t  instr_0,
   input  rename_pkg::dec_instr_t  instr_1,
   input  logic                    wr_en_0,     // Instr 0 allocates
   input  logic                    wr_en_1,
   input  logic [`PRF_WIDTH-1:0]   new_prf_0,
   input  logic [`PRF_WIDTH-1:0]   new_prf_1,
   input  rename_pkg::walk_t       walk_0,      // Already gated by walk_en
   input  rename_pkg::walk_t       walk_1,
   output rename_pkg::rename_out_t ren_0,
   output rename_pkg::rename_out_t ren_1
);

   logic [`PRF_WIDTH-1:0] rat [`NUM_ARF];

   logic [`PRF_WIDTH-1:0] rs1_0, rs2_0, old_0;
   logic [`PRF_WIDTH-1:0] rs1_1, rs2_1, old_1;

   // Table read with forwarding from instr 0 of the same pair
   function automatic logic [`PRF_WIDTH-1:0] lookup_byp(
      input logic [`ARF_WIDTH-1:0] arf_id,
      input logic                  byp_en,
      input logic [`ARF_WIDTH-1:0] byp_rd,
      input logic [`PRF_WIDTH-1:0] byp_prf,
      input logic [`PRF_WIDTH-1:0] tbl_prf
   );
      logic hit;
      hit = byp_en && (arf_id == byp_rd);
      return hit ? byp_prf : tbl_prf;
   endfunction

   // Instr 0 sees the table as is
   assign rs1_0 = rat[instr_0.rs1_id];
   assign rs2_0 = rat[instr_0.rs2_id];
   assign old_0 = rat[instr_0.rd_id];

   // Instr 1 depends on instr 0 when they share a register
   assign rs1_1 = lookup_byp(instr_1.rs1_id, wr_en_0, instr_0.rd_id, new_prf_0,
                             rat[instr_1.rs1_id]);
   assign rs2_1 = lookup_byp(instr_1.rs2_id, wr_en_0, instr_0.rd_id, new_prf_0,
                             rat[instr_1.rs2_id]);
   assign old_1 = lookup_byp(instr_1.rd_id, wr_en_0, instr_0.rd_id, new_prf_0,
                             rat[instr_1.rd_id]);  // Same rd, old is instr 0's new

   always_comb begin
      ren_0.prf_rs1 = rs1_0;
      ren_0.prf_rs2 = rs2_0;
      ren_0.t_new   = wr_en_0 ? new_prf_0 : '0;  // Zero when nothing allocated
      ren_0.t_old   = wr_en_0 ? old_0     : '0;
      ren_1.prf_rs1 = rs1_1;
      ren_1.prf_rs2 = rs2_1;
      ren_1.t_new   = wr_en_1 ? new_prf_1 : '0;
      ren_1.t_old   = wr_en_1 ? old_1     : '0;
   end

   // Later assignment wins, so instr 1 beats instr 0 and walk_1 lands last
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `NUM_ARF; i++) begin
            rat[i] <= `PRF_WIDTH'(i);  // Identity map
         end
      end else begin
         if (wr_en_0) begin
            rat[instr_0.rd_id] <= new_prf_0;
         end
         if (wr_en_1) begin
            rat[instr_1.rd_id] <= new_prf_1;
         end
         if (walk_0.valid) begin
            rat[walk_0.rd_id] <= walk_0.rd_prf;
         end
         if (walk_1.valid) begin
            rat[walk_1.rd_id] <= walk_1.rd_prf;
         end
      end
   end

   // Walk and rename writes never meet
   // rename_en and walk_en come from different FSM states

endmodule
`default_nettype wire

//--- rename/rename_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_consts.svh"

module rename_stage (
   input  logic                    clk,
   input  logic                    rst_n,
   input  rename_pkg::dec_instr_t  dec_instr_0,
   input  rename_pkg::dec_instr_t  dec_instr_1,
   input  rename_pkg::release_t    release_0,   // From retire
   input  rename_pkg::release_t    release_1,
   input  rename_pkg::rob_state_e  rob_state,
   input  logic                    fl_walk_0,   // Free list walk strobes
   input  logic                    fl_walk_1,
   input  rename_pkg::walk_t       rat_walk_0,  // Alias table restores
   input  rename_pkg::walk_t       rat_walk_1,
   output rename_pkg::rename_out_t ren_0,
   output rename_pkg::rename_out_t ren_1,
   output logic                    can_alloc,
   output logic                    rename_en    // Pair accepted this cycle
);
   import rename_pkg::*;

   logic                  walk_en;
   logic                  alloc_req_0, alloc_req_1;
   logic                  pop_0, pop_1;
   logic [`PRF_WIDTH-1:0] head_prf_0, head_prf_1;
   logic [`PRF_WIDTH-1:0] new_prf_0, new_prf_1;
   logic [1:0]            pop_cnt, push_cnt, walk_cnt;
   walk_t                 walk_g_0, walk_g_1;

   // Reg 0 never gets a new id
   assign alloc_req_0 = dec_instr_0.is_valid & dec_instr_0.reg_write &
                        (dec_instr_0.rd_id != '0) & rename_en & can_alloc;
   assign alloc_req_1 = dec_instr_1.is_valid & dec_instr_1.reg_write &
                        (dec_instr_1.rd_id != '0) & rename_en & can_alloc;

   // Keep pops compact, slot 0 first
   assign pop_0 = alloc_req_0 | alloc_req_1;
   assign pop_1 = alloc_req_0 & alloc_req_1;

   assign new_prf_0 = head_prf_0;
   assign new_prf_1 = alloc_req_0 ? head_prf_1 : head_prf_0;  // Lone instr 1 takes head

   assign pop_cnt  = {1'b0, alloc_req_0} + {1'b0, alloc_req_1};
   assign push_cnt = {1'b0, release_0.valid} + {1'b0, release_1.valid};
   assign walk_cnt = walk_en ? ({1'b0, fl_walk_0} + {1'b0, fl_walk_1}) : 2'd0;

   // Table restores only count while walking
   assign walk_g_0 = '{valid: rat_walk_0.valid & walk_en,
                       rd_id: rat_walk_0.rd_id, rd_prf: rat_walk_0.rd_prf};
   assign walk_g_1 = '{valid: rat_walk_1.valid & walk_en,
                       rd_id: rat_walk_1.rd_id, rd_prf: rat_walk_1.rd_prf};

   recovery_fsm u_fsm (
      .clk       (clk),
      .rst_n     (rst_n),
      .rob_state (rob_state),
      .rename_en (rename_en),
      .walk_en   (walk_en)
   );

   free_count u_cnt (
      .clk       (clk),
      .rst_n     (rst_n),
      .pop_cnt   (pop_cnt),
      .push_cnt  (push_cnt),
      .walk_cnt  (walk_cnt),
      .can_alloc (can_alloc)
   );

   free_list u_fl (
      .clk        (clk),
      .rst_n      (rst_n),
      .pop_0      (pop_0),
      .pop_1      (pop_1),
      .release_0  (release_0),
      .release_1  (release_1),
      .walk_en    (walk_en),
      .fl_walk_0  (fl_walk_0),
      .fl_walk_1  (fl_walk_1),
      .head_prf_0 (head_prf_0),
      .head_prf_1 (head_prf_1)
   );

   map_table u_mt (
      .clk       (clk),
      .rst_n     (rst_n),
      .instr_0   (dec_instr_0),
      .instr_1   (dec_instr_1),
      .wr_en_0   (alloc_req_0),
      .wr_en_1   (alloc_req_1),
      .new_prf_0 (new_prf_0),
      .new_prf_1 (new_prf_1),
      .walk_0    (walk_g_0),
      .walk_1    (walk_g_1),
      .ren_0     (ren_0),
      .ren_1     (ren_1)
   );

endmodule
`default_nettype wire

//--- dv/tb_rename_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_consts.svh"

module tb_rename_stage;
   import rename_pkg::*;

   typedef struct {
      dec_instr_t i0, i1;
      release_t   r0, r1;
      rob_state_e rob;
      logic       fw0, fw1;     // Free list walk strobes
      walk_t      w0, w1;       // rd_prf filled from snapshot when applied
      logic       snap;         // Save model table before this row's writes
      logic       wait_run;     // Idle until rename_en is back
      logic       chk;
   } row_t;

   localparam dec_instr_t NOP_I  = '0;
   localparam release_t   NO_REL = '0;
   localparam walk_t      NO_WK  = '0;

   logic        clk, rst_n;
   dec_instr_t  dec_instr_0, dec_instr_1;
   release_t    release_0, release_1;
   rob_state_e  rob_state;
   logic        fl_walk_0, fl_walk_1;
   walk_t       rat_walk_0, rat_walk_1;
   rename_out_t ren_0, ren_1;
   logic        can_alloc, rename_en;

   // Reference model
   logic [`PRF_WIDTH-1:0] rat_m [`NUM_ARF];
   logic [`PRF_WIDTH-1:0] snap_rat [`NUM_ARF];
   logic [`PRF_WIDTH-1:0] fl_q [$];     // Free ids, head first
   logic [`PRF_WIDTH-1:0] given_q [$];  // Ids handed out, oldest first
   recov_state_e          st_m;
   row_t                  rows [$];
   int                    errors = 0;
   integer                seed = 32'hac6e;

   rename_stage u_dut (
      .clk (clk), .rst_n (rst_n),
      .dec_instr_0 (dec_instr_0), .dec_instr_1 (dec_instr_1),
      .release_0 (release_0), .release_1 (release_1),
      .rob_state (rob_state),
      .fl_walk_0 (fl_walk_0), .fl_walk_1 (fl_walk_1),
      .rat_walk_0 (rat_walk_0), .rat_walk_1 (rat_walk_1),
      .ren_0 (ren_0), .ren_1 (ren_1),
      .can_alloc (can_alloc), .rename_en (rename_en)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   function automatic dec_instr_t ins(input logic v, input logic w, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [4:0] rs2);
      return '{is_valid: v, reg_write: w, rd_id: rd, rs1_id: rs1, rs2_id: rs2};
   endfunction

   function automatic release_t rel(input logic v, input logic [5:0] id);
      return '{valid: v, prf_id: id};
   endfunction

   function automatic walk_t wk(input logic v, input logic [4:0] rd);
      return '{valid: v, rd_id: rd, rd_prf: 6'd0};
   endfunction

   task automatic check_val(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         $display("Done: errors found");
         $fatal(1, "Mismatch on %s", what);
      end
   endtask

   task automatic add_row(input dec_instr_t i0, input dec_instr_t i1, input release_t r0,
                          input release_t r1, input rob_state_e rob, input logic fw0,
                          input logic fw1, input walk_t w0, input walk_t w1,
                          input logic snap, input logic wait_run);
      row_t r;
      r = '{i0: i0, i1: i1, r0: r0, r1: r1, rob: rob, fw0: fw0, fw1: fw1,
            w0: w0, w1: w1, snap: snap, wait_run: wait_run, chk: 1'b1};
      rows.push_back(r);
   endtask

   task automatic add_pair(input dec_instr_t i0, input dec_instr_t i1);
      add_row(i0, i1, NO_REL, NO_REL, ROB_NORMAL, 1'b0, 1'b0, NO_WK, NO_WK, 1'b0, 1'b0);
   endtask

   task automatic apply_row(input row_t r);
      logic                  en, ca, a0, a1;
      logic [`PRF_WIDTH-1:0] n0, n1;
      rename_out_t           e0, e1;
      // Ring holds FL_DEPTH ids at most
      if (fl_q.size() + r.r0.valid + r.r1.valid > `FL_DEPTH) begin
         r.r0.valid = 1'b0;
         r.r1.valid = 1'b0;
      end
      r.w0.rd_prf = snap_rat[r.w0.rd_id];
      r.w1.rd_prf = snap_rat[r.w1.rd_id];
      @(posedge clk);
      dec_instr_0 <= r.i0;
      dec_instr_1 <= r.i1;
      release_0   <= r.r0;
      release_1   <= r.r1;
      rob_state   <= r.rob;
      fl_walk_0   <= r.fw0;
      fl_walk_1   <= r.fw1;
      rat_walk_0  <= r.w0;
      rat_walk_1  <= r.w1;
      @(negedge clk);
      en = (st_m == ST_RUN);
      ca = (fl_q.size() >= 2);
      a0 = r.i0.is_valid && r.i0.reg_write && (r.i0.rd_id != 0) && en && ca;
      a1 = r.i1.is_valid && r.i1.reg_write && (r.i1.rd_id != 0) && en && ca;
      n0 = ca ? fl_q[0] : '0;
      n1 = !ca ? '0 : (a0 ? fl_q[1] : fl_q[0]);   // Lone instr 1 takes the head id
      e0.prf_rs1 = rat_m[r.i0.rs1_id];
      e0.prf_rs2 = rat_m[r.i0.rs2_id];
      e0.t_new   = a0 ? n0 : '0;
      e0.t_old   = a0 ? rat_m[r.i0.rd_id] : '0;
      e1.prf_rs1 = (a0 && r.i1.rs1_id == r.i0.rd_id) ? n0 : rat_m[r.i1.rs1_id];
      e1.prf_rs2 = (a0 && r.i1.rs2_id == r.i0.rd_id) ? n0 : rat_m[r.i1.rs2_id];
      e1.t_new   = a1 ? n1 : '0;
      e1.t_old   = !a1 ? '0 : ((a0 && r.i1.rd_id == r.i0.rd_id) ? n0 : rat_m[r.i1.rd_id]);
      if (r.chk) begin
         check_val("rename_en", rename_en, en);
         check_val("can_alloc", can_alloc, ca);
         check_val("ren_0", ren_0, e0);
         check_val("ren_1", ren_1, e1);
      end
      if (r.snap) snap_rat = rat_m;
      // Model state for the next edge
      if (a0 || a1) given_q.push_back(fl_q.pop_front());
      if (a0 && a1) given_q.push_back(fl_q.pop_front());
      if (a0) rat_m[r.i0.rd_id] = n0;
      if (a1) rat_m[r.i1.rd_id] = n1;   // Clash goes to instr 1
      if (st_m == ST_WALK) begin
         if (r.w0.valid) rat_m[r.w0.rd_id] = r.w0.rd_prf;
         if (r.w1.valid) rat_m[r.w1.rd_id] = r.w1.rd_prf;
         if (r.fw0) fl_q.push_front(given_q.pop_back());
         if (r.fw1) fl_q.push_front(given_q.pop_back());
      end
      if (r.r0.valid) fl_q.push_back(r.r0.prf_id);
      if (r.r1.valid) fl_q.push_back(r.r1.prf_id);
      case (st_m)
         ST_RUN:  if (r.rob == ROB_RECOVER) st_m = ST_WALK;
         ST_WALK: if (r.rob != ROB_RECOVER) st_m = ST_RESUME;
         default: st_m = (r.rob == ROB_RECOVER) ? ST_WALK : ST_RUN;
      endcase
   endtask

   task automatic wait_rename_en();
      row_t idle;
      int   n;
      idle = '{i0: NOP_I, i1: NOP_I, r0: NO_REL, r1: NO_REL, rob: ROB_NORMAL, fw0: 1'b0,
               fw1: 1'b0, w0: NO_WK, w1: NO_WK, snap: 1'b0, wait_run: 1'b0, chk: 1'b1};
      n = 0;
      while (rename_en !== 1'b1) begin
         if (n == 16) begin
            $display("Timeout: rename_en did not come back after recovery");
            $display("Done: errors found");
            $fatal(1, "rename_en timeout");
         end
         apply_row(idle);
         n++;
      end
   endtask

   task automatic build_directed();
      add_pair(ins(1, 1, 3, 1, 2), ins(1, 1, 4, 5, 6));     // First ids after reset
      add_pair(ins(1, 1, 7, 1, 2), ins(1, 1, 8, 7, 3));     // rs1 of instr 1 bypassed
      add_pair(ins(1, 1, 9, 7, 8), ins(1, 1, 9, 9, 4));     // Same rd in both
      add_pair(ins(1, 1, 11, 9, 9), ins(0, 1, 12, 9, 7));   // Reads the clash winner
      add_pair(ins(0, 1, 13, 1, 1), ins(1, 0, 14, 2, 2));   // Nothing allocates
      add_pair(ins(1, 1, 0, 3, 4), ins(1, 1, 10, 0, 9));    // rd 0, lone instr 1
      // Drain the free list, last two pairs stall
      for (int k = 0; k < 14; k++) begin
         add_pair(ins(1, 1, 5'(1 + (2 * k) % 31), 5'(k), 5'(k + 1)),
                  ins(1, 1, 5'(1 + (2 * k + 1) % 31), 5'(k + 2), 5'(2 * k)));
      end
      add_row(NOP_I, NOP_I, rel(1, 3), rel(1, 4), ROB_NORMAL, 0, 0, NO_WK, NO_WK, 0, 0);
      add_row(ins(1, 1, 20, 3, 4), ins(1, 1, 21, 20, 5), rel(1, 7), rel(1, 8),
              ROB_NORMAL, 0, 0, NO_WK, NO_WK, 0, 0);
      add_row(ins(1, 1, 22, 1, 2), ins(1, 1, 23, 22, 21), rel(1, 11), NO_REL,
              ROB_NORMAL, 0, 0, NO_WK, NO_WK, 0, 0);
      add_row(NOP_I, NOP_I, rel(1, 12), rel(1, 13), ROB_NORMAL, 0, 0, NO_WK, NO_WK, 0, 0);
      add_row(NOP_I, NOP_I, rel(1, 14), rel(1, 15), ROB_NORMAL, 0, 0, NO_WK, NO_WK, 0, 0);
      // Mispredicted pair is the second one, walked back below
      add_pair(ins(1, 1, 5, 1, 2), ins(1, 1, 6, 5, 3));
      add_row(ins(1, 1, 5, 6, 1), ins(1, 1, 9, 5, 2), NO_REL, NO_REL,
              ROB_NORMAL, 0, 0, NO_WK, NO_WK, 1, 0);
      add_row(NOP_I, NOP_I, NO_REL, NO_REL, ROB_RECOVER, 0, 0, NO_WK, NO_WK, 0, 0);
      add_row(NOP_I, NOP_I, NO_REL, NO_REL, ROB_RECOVER, 1, 1, wk(1, 5), wk(1, 9), 0, 0);
      add_row(ins(0, 0, 0, 5, 9), NOP_I, rel(1, 16), NO_REL,
              ROB_RECOVER, 0, 0, NO_WK, NO_WK, 0, 0);        // Release while walking
      add_row(ins(0, 0, 0, 9, 6), NOP_I, NO_REL, NO_REL, ROB_NORMAL, 0, 0, NO_WK, NO_WK, 0, 0);
      add_row(ins(1, 1, 12, 5, 9), ins(1, 1, 13, 12, 6), NO_REL, NO_REL,
              ROB_NORMAL, 0, 0, NO_WK, NO_WK, 0, 1);         // Reuses walked ids
   endtask

   initial begin
      logic [31:0] rv;
      dec_instr_t  ri0, ri1;
      release_t    rr0, rr1;
      rst_n       <= 1'b0;
      dec_instr_0 <= NOP_I;
      dec_instr_1 <= NOP_I;
      release_0   <= NO_REL;
      release_1   <= NO_REL;
      rob_state   <= ROB_NORMAL;
      fl_walk_0   <= 1'b0;
      fl_walk_1   <= 1'b0;
      rat_walk_0  <= NO_WK;
      rat_walk_1  <= NO_WK;
      for (int i = 0; i < `NUM_ARF; i++) begin
         rat_m[i]    = 6'(i);
         snap_rat[i] = 6'(i);
      end
      for (int i = 0; i < `FL_DEPTH; i++) fl_q.push_back(6'(`NUM_ARF + i));
      st_m = ST_RUN;
      build_directed();
      for (int k = 0; k < 40; k++) begin
         rv  = $random(seed);
         ri0 = ins(rv[0] | rv[1], rv[2], rv[7:3], rv[12:8], rv[17:13]);
         ri1 = ins(rv[18] | rv[19], rv[20], rv[25:21], rv[30:26], rv[4:0]);
         rv  = $random(seed);
         rr0 = rel(rv[0] & rv[1], rv[7:2]);
         rr1 = rel(rv[8] & rv[9], rv[15:10]);
         add_row(ri0, ri1, rr0, rr1, ROB_NORMAL, 0, 0, NO_WK, NO_WK, 0, 0);
      end
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      foreach (rows[i]) begin
         if (rows[i].wait_run) wait_rename_en();
         apply_row(rows[i]);
      end
      if (errors == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("Done: errors found");
         $fatal(1, "Checks failed");
      end
   end

endmodule
`default_nettype wire

//--- vlog.f
+incdir+common
common/rename_pkg.sv
logic/recovery_fsm.sv
logic/free_count.sv
rename/free_list.sv
rename/map_table.sv
rename/rename_stage.sv
dv/tb_rename_stage.sv

//--- Bender.yml
package:
  name: rename_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rename_pkg.sv
      - logic/recovery_fsm.sv
      - logic/free_count.sv
      - rename/free_list.sv
      - rename/map_table.sv
      - rename/rename_stage.sv
      - target: test
        include_dirs:
          - common
        files:
          - dv/tb_rename_stage.sv
